//--- logic/soc_bus_defines.svh
`ifndef SOC_BUS_DEFINES_SVH
`define SOC_BUS_DEFINES_SVH

// RAM depth in 32-bit words.
`define RAM_WORDS 512

// The RAM occupies RAM_WORDS * 4 bytes starting here.
`define RAM_BASE 32'h0000_0000

// System register block, aligned to its own size.
`define SYS_BASE 32'h0001_0000
`define SYS_SIZE 32'h0000_0100

// Register offsets inside the system block.
`define SYS_LEDS       8'h00
`define SYS_COUNT_LO   8'h04
`define SYS_COUNT_HI   8'h08
`define SYS_COMPARE_LO 8'h0c
`define SYS_COMPARE_HI 8'h10

`endif

//--- logic/soc_bus_pkg.sv
package soc_bus_pkg;

    // Full request as seen on the data port and on the shared bus.
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [3:0]  write_mask;
        logic [31:0] write_value;
    } bus_req_t;

    // Instruction fetches only ever read.
    typedef struct packed {
        logic [31:0] address;
        logic        read;
    } instr_req_t;

    typedef struct packed {
        logic [31:0] read_value;
        logic        ready;
        logic        fault;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        grant_none,
        grant_instr,
        grant_data
    } grant_t;

    // Replaces the bytes of old_value selected by mask.
    function automatic logic [31:0] apply_mask(input logic [31:0] old_value,
                                               input logic [31:0] new_value,
                                               input logic [3:0]  mask);
        logic [31:0] merged;
        merged = old_value;
        for (int i = 0; i < 4; i++) begin
            if (mask[i])
                merged[i*8 +: 8] = new_value[i*8 +: 8];
        end
        return merged;
    endfunction

endpackage

//--- logic/bus_arbiter.sv
module bus_arbiter import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  instr_req_t instr_req,
    output bus_rsp_t   instr_rsp,

    input  bus_req_t   data_req,
    output bus_rsp_t   data_rsp,

    output bus_req_t   mem_req,
    input  bus_rsp_t   mem_rsp
);

    grant_t   grant_q;  // Owner of an access that is still in flight.
    grant_t   grant;    // Owner for this cycle.
    logic     instr_active;
    logic     data_active;
    bus_req_t instr_as_bus;

    assign instr_active = instr_req.read;
    assign data_active  = data_req.read | data_req.write;

    // The fetch port is widened to the full request with no write.
    always_comb begin
        instr_as_bus             = '0;
        instr_as_bus.address     = instr_req.address;
        instr_as_bus.read        = instr_req.read;
    end

    // A held grant is never taken away. From idle, data wins a tie.
    always_comb begin
        grant = grant_q;
        if (grant_q == grant_none) begin
            if (data_active)
                grant = grant_data;
            else if (instr_active)
                grant = grant_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            grant_q <= grant_none;
        else if (mem_rsp.ready)
            grant_q <= grant_none;  // Access done, free the bus on the next edge.
        else
            grant_q <= grant;
    end

    always_comb begin
        case (grant)
            grant_instr: mem_req = instr_as_bus;
            grant_data:  mem_req = data_req;
            default:     mem_req = '0;
        endcase
    end

    // The requester that is not granted sees an all-zero response and waits.
    assign instr_rsp = (grant == grant_instr) ? mem_rsp : '0;
    assign data_rsp  = (grant == grant_data)  ? mem_rsp : '0;

endmodule

//--- logic/bus_decoder.sv
`include "soc_bus_defines.svh"

module bus_decoder import soc_bus_pkg::*; (
    input  bus_req_t mem_req,

    input  bus_rsp_t ram_rsp,
    input  bus_rsp_t sys_rsp,

    output logic     ram_sel,
    output logic     sys_sel,
    output bus_rsp_t mem_rsp
);

    localparam logic [31:0] RAM_BYTES = `RAM_WORDS * 4;

    logic active;
    logic ram_hit;
    logic sys_hit;
    logic fault;

    assign active = mem_req.read | mem_req.write;

    assign ram_hit = (mem_req.address - `RAM_BASE) < RAM_BYTES;
    assign sys_hit = (mem_req.address & ~(`SYS_SIZE - 32'd1)) == `SYS_BASE;

    always_comb begin
        ram_sel = 1'b0;
        sys_sel = 1'b0;
        fault   = 1'b0;

        if (active) begin
            unique case (1'b1)
                ram_hit: ram_sel = 1'b1;
                sys_hit: sys_sel = 1'b1;
                default: fault   = 1'b1;  // Nothing mapped here.
            endcase
        end
    end

    // Unselected targets drive zero, so their responses can simply be ORed.
    always_comb begin
        mem_rsp.read_value = ram_rsp.read_value | sys_rsp.read_value;
        mem_rsp.ready      = ram_rsp.ready | sys_rsp.ready | fault;
        mem_rsp.fault      = fault;
    end

endmodule

//--- logic/ram.sv
`include "soc_bus_defines.svh"

module ram import soc_bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  bus_req_t mem_req,
    input  logic     sel,
    output bus_rsp_t rsp
);

    localparam int INDEX_BITS = $clog2(`RAM_WORDS);

    logic [31:0]           mem [`RAM_WORDS];
    logic [INDEX_BITS-1:0] index;
    logic [31:0]           read_q;
    logic                  ready_q;

    assign index = mem_req.address[INDEX_BITS+1:2];

    // Ready is a single pulse, so a request that is still held is not answered twice.
    always_ff @(posedge clk) begin
        if (reset)
            ready_q <= 1'b0;
        else
            ready_q <= sel && !ready_q;
    end

    always_ff @(posedge clk) begin
        if (sel && !ready_q)
            read_q <= mem[index];
        if (sel && ready_q && mem_req.write)  // Write once, in the ready cycle.
            mem[index] <= apply_mask(mem[index], mem_req.write_value, mem_req.write_mask);
    end

    always_comb begin
        rsp.read_value = ready_q ? read_q : 32'd0;
        rsp.ready      = ready_q;
        rsp.fault      = 1'b0;
    end

endmodule

//--- logic/system_regs.sv
`include "soc_bus_defines.svh"

module system_regs import soc_bus_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  bus_req_t    mem_req,
    input  logic        sel,
    output bus_rsp_t    rsp,

    input  logic [63:0] count,
    output logic [63:0] compare,
    output logic [7:0]  leds
);

    logic [7:0]  offset;
    logic        write_en;
    logic [31:0] read_value;

    assign offset   = mem_req.address[7:0];
    assign write_en = sel && mem_req.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            leds    <= 8'd0;
            compare <= '1;  // Far in the future, so no interrupt out of reset.
        end else if (write_en) begin
            case (offset)
                `SYS_LEDS: begin
                    if (mem_req.write_mask[0])
                        leds <= mem_req.write_value[7:0];
                end
                `SYS_COMPARE_LO:
                    compare[31:0] <= apply_mask(compare[31:0], mem_req.write_value,
                                                mem_req.write_mask);
                `SYS_COMPARE_HI:
                    compare[63:32] <= apply_mask(compare[63:32], mem_req.write_value,
                                                 mem_req.write_mask);
                default: ;  // The count is read only.
            endcase
        end
    end

    always_comb begin
        case (offset)
            `SYS_LEDS:       read_value = {24'd0, leds};
            `SYS_COUNT_LO:   read_value = count[31:0];
            `SYS_COUNT_HI:   read_value = count[63:32];
            `SYS_COMPARE_LO: read_value = compare[31:0];
            `SYS_COMPARE_HI: read_value = compare[63:32];
            default:         read_value = 32'd0;
        endcase
    end

    // Registers answer in the cycle they are selected.
    always_comb begin
        rsp.read_value = sel ? read_value : 32'd0;
        rsp.ready      = sel;
        rsp.fault      = 1'b0;
    end

endmodule

//--- logic/timer_counter.sv
module timer_counter (
    input  logic        clk,
    input  logic        reset,

    input  logic [63:0] compare,
    output logic [63:0] count,
    output logic        irq
);

    always_ff @(posedge clk) begin
        if (reset)
            count <= 64'd0;
        else
            count <= count + 64'd1;
    end

    // A level, not a pulse. It drops only once compare moves past the count.
    always_ff @(posedge clk) begin
        if (reset)
            irq <= 1'b0;
        else
            irq <= count >= compare;
    end

endmodule

//--- logic/soc_bus.sv
module soc_bus import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    input  instr_req_t instr_req,
    output bus_rsp_t   instr_rsp,

    input  bus_req_t   data_req,
    output bus_rsp_t   data_rsp,

    output logic [7:0] leds,
    output logic       timer_irq
);

    bus_req_t    mem_req;
    bus_rsp_t    mem_rsp;
    bus_rsp_t    ram_rsp;
    bus_rsp_t    sys_rsp;
    logic        ram_sel;
    logic        sys_sel;
    logic [63:0] count;
    logic [63:0] compare;

    bus_arbiter bus_arbiter_i (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .instr_rsp (instr_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    bus_decoder bus_decoder_i (
        .mem_req (mem_req),
        .ram_rsp (ram_rsp),
        .sys_rsp (sys_rsp),
        .ram_sel (ram_sel),
        .sys_sel (sys_sel),
        .mem_rsp (mem_rsp)
    );

    ram ram_i (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .sel     (ram_sel),
        .rsp     (ram_rsp)
    );

    system_regs system_regs_i (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .sel     (sys_sel),
        .rsp     (sys_rsp),
        .count   (count),
        .compare (compare),
        .leds    (leds)
    );

    timer_counter timer_counter_i (
        .clk     (clk),
        .reset   (reset),
        .compare (compare),
        .count   (count),
        .irq     (timer_irq)
    );

endmodule

//--- verification/soc_bus_properties.sv
module soc_bus_properties import soc_bus_pkg::*; (
    input logic     clk,
    input logic     reset,
    input grant_t   grant_q,
    input bus_req_t mem_req,
    input bus_rsp_t mem_rsp,
    input bus_rsp_t ram_rsp,
    input logic     ram_sel
);

    // An access in flight keeps its owner, so the shared request stays put until ready.
    grant_held: assert property (@(posedge clk) disable iff (reset)
        ((mem_req.read || mem_req.write) && !mem_rsp.ready)
            |=> (grant_q != grant_none && $stable(mem_req)))
        else $error("shared request changed while an access was waiting");

    // Two ready cycles in a row belong to two different accesses.
    ready_once: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.ready |=> (!mem_rsp.ready || !$stable(mem_req)))
        else $error("one access was answered twice");

    fault_ready: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.fault |-> (mem_rsp.ready && mem_rsp.read_value == 32'd0))
        else $error("fault without ready or with nonzero data");

    // The RAM answers only while its own access is still selected.
    one_select: assert property (@(posedge clk) disable iff (reset)
        ram_rsp.ready |-> ram_sel)
        else $error("RAM answered an access that was no longer selected");

endmodule

// The top level holds both the arbiter and the decoder signals.
bind soc_bus soc_bus_properties properties_i (
    .clk     (clk),
    .reset   (reset),
    .grant_q (bus_arbiter_i.grant_q),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .ram_rsp (ram_rsp),
    .ram_sel (ram_sel)
);

//--- verification/soc_bus_tb.sv
`include "soc_bus_defines.svh"

module soc_bus_tb import soc_bus_pkg::*; ();

    localparam int INDEX_BITS = $clog2(`RAM_WORDS);
    localparam int TXN_LIMIT = 200;  // Upper bound on bus transactions in all tests.
    localparam int IRQ_WAIT = 150;   // Extra cycles spent waiting on the timer.

    logic       clk;
    logic       reset;
    instr_req_t instr_req;
    bus_rsp_t   instr_rsp;
    bus_req_t   data_req;
    bus_rsp_t   data_rsp;
    logic [7:0] leds;
    logic       timer_irq;

    logic [31:0] model_ram [`RAM_WORDS];
    logic [7:0]  model_leds;
    logic [63:0] model_compare;
    logic [63:0] model_count;
    logic        exp_irq;
    logic [31:0] lfsr_state;
    logic [31:0] addr_list [24];
    time         data_done_at;
    time         instr_done_at;
    int          value_errors;
    int          other_errors;

    soc_bus dut_i (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .instr_rsp (instr_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .leds      (leds),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1; one step per bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_value,
                                                input logic [31:0] new_value,
                                                input logic [3:0]  mask);
        logic [31:0] keep_new;
        keep_new = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old_value & ~keep_new) | (new_value & keep_new);
    endfunction

    function automatic bus_req_t to_bus_req(input instr_req_t req);
        bus_req_t r;
        r = '0;
        r.address = req.address;
        r.read    = req.read;
        return r;
    endfunction

    // Expected response from the address map and the model state.
    function automatic bus_rsp_t reference_rsp(input bus_req_t req);
        bus_rsp_t    r;
        logic [31:0] a;
        a = req.address;
        r = '0;
        r.ready = 1'b1;
        if (a[31:INDEX_BITS+2] == '0) begin
            r.read_value = model_ram[a[INDEX_BITS+1:2]];
        end else if (a >= `SYS_BASE && a < `SYS_BASE + `SYS_SIZE) begin
            case (a[7:0])
                `SYS_LEDS:       r.read_value = {24'd0, model_leds};
                `SYS_COUNT_LO:   r.read_value = model_count[31:0];
                `SYS_COUNT_HI:   r.read_value = model_count[63:32];
                `SYS_COMPARE_LO: r.read_value = model_compare[31:0];
                `SYS_COMPARE_HI: r.read_value = model_compare[63:32];
                default:         r.read_value = 32'd0;
            endcase
        end else begin
            r.fault = 1'b1;
        end
        return r;
    endfunction

    task automatic apply_write(input bus_req_t req);
        logic [31:0] a;
        a = req.address;
        if (a[31:INDEX_BITS+2] == '0) begin
            model_ram[a[INDEX_BITS+1:2]] = merge_bytes(model_ram[a[INDEX_BITS+1:2]],
                                                       req.write_value, req.write_mask);
        end else if (a[7:0] == `SYS_LEDS && req.write_mask[0]) begin
            model_leds = req.write_value[7:0];
        end else if (a[7:0] == `SYS_COMPARE_LO) begin
            model_compare[31:0] = merge_bytes(model_compare[31:0], req.write_value,
                                              req.write_mask);
        end else if (a[7:0] == `SYS_COMPARE_HI) begin
            model_compare[63:32] = merge_bytes(model_compare[63:32], req.write_value,
                                               req.write_mask);
        end
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act,
                             input bit with_value);
        bus_rsp_t e;
        e = exp;
        if (!with_value)
            e.read_value = act.read_value;  // Write responses carry no defined data.
        if (act !== e) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, e, act);
            value_errors++;
        end
    endtask

    task automatic check_leds(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERR %0t leds expected %h actual %h", $time, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_irq(input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t timer_irq expected %b actual %b", $time, exp, act);
            value_errors++;
        end
    endtask

    // Samples pre-edge values, then advances the model past this edge.
    always @(posedge clk) begin : compare_proc
        bus_rsp_t exp;
        if (reset) begin
            model_count = 64'd0;
            exp_irq = 1'b0;
        end else begin
            check_leds(model_leds, leds);
            check_irq(exp_irq, timer_irq);
            exp_irq = model_count >= model_compare;
            if (data_rsp.ready) begin
                exp = reference_rsp(data_req);
                check_rsp("data_rsp", exp, data_rsp, data_req.read || exp.fault);
                data_done_at = $time;
                if (data_req.write && !exp.fault)
                    apply_write(data_req);
            end
            if (instr_rsp.ready) begin
                exp = reference_rsp(to_bus_req(instr_req));
                check_rsp("instr_rsp", exp, instr_rsp, 1'b1);
                instr_done_at = $time;
            end
            model_count = model_count + 64'd1;
        end
    end

    // Called on a falling edge, returns on a falling edge.
    task automatic data_access(input bus_req_t req, output bus_rsp_t rsp);
        data_req = req;
        do @(posedge clk); while (!data_rsp.ready);
        rsp = data_rsp;
        @(negedge clk);
        data_req = '0;
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [31:0] value,
                              input logic [3:0] mask);
        bus_req_t req;
        bus_rsp_t rsp;
        req = '0;
        req.address     = addr;
        req.write       = 1'b1;
        req.write_mask  = mask;
        req.write_value = value;
        data_access(req, rsp);
    endtask

    task automatic data_read(input logic [31:0] addr, output logic [31:0] value);
        bus_req_t req;
        bus_rsp_t rsp;
        req = '0;
        req.address = addr;
        req.read    = 1'b1;
        data_access(req, rsp);
        value = rsp.read_value;
    endtask

    task automatic instr_read(input logic [31:0] addr, output logic [31:0] value);
        instr_req.address = addr;
        instr_req.read    = 1'b1;
        do @(posedge clk); while (!instr_rsp.ready);
        value = instr_rsp.read_value;
        @(negedge clk);
        instr_req = '0;
    endtask

    task automatic ram_test();
        logic [31:0] v;
        int          j;
        for (int i = 0; i < 24; i++) begin
            addr_list[i] = {21'd0, INDEX_BITS'(take_bits(INDEX_BITS)), 2'b00};
            data_write(addr_list[i], take_bits(32), 4'hf);
        end
        for (int i = 0; i < 48; i++) begin
            j = take_bits(5) % 24;
            data_write(addr_list[j], take_bits(32), 4'(take_bits(4)));
        end
        for (int i = 0; i < 24; i++) begin
            data_read(addr_list[i], v);
            instr_read(addr_list[i], v);
        end
    endtask

    task automatic fault_test();
        logic [31:0] a;
        logic [31:0] v;
        for (int i = 0; i < 2; i++) begin
            a = 32'h4000_0000 | {4'd0, 26'(take_bits(26)), 2'b00};  // Far outside both regions.
            data_read(a, v);
            data_write(a, take_bits(32), 4'hf);
            instr_read(a, v);
        end
    endtask

    task automatic led_count_test();
        logic [31:0] v;
        logic [31:0] lo_before;
        logic [31:0] hi_before;
        logic [31:0] lo_after;
        logic [31:0] hi_after;
        for (int i = 0; i < 4; i++) begin
            data_write(`SYS_BASE + `SYS_LEDS, take_bits(8), 4'h1);
            data_read(`SYS_BASE + `SYS_LEDS, v);
        end
        data_read(`SYS_BASE + `SYS_COUNT_LO, lo_before);
        data_read(`SYS_BASE + `SYS_COUNT_HI, hi_before);
        data_write(`SYS_BASE + `SYS_COUNT_LO, 32'd0, 4'hf);
        data_write(`SYS_BASE + `SYS_COUNT_HI, 32'd0, 4'hf);
        data_read(`SYS_BASE + `SYS_COUNT_LO, lo_after);
        data_read(`SYS_BASE + `SYS_COUNT_HI, hi_after);
        if (hi_after < hi_before || {hi_after, lo_after} <= {hi_before, lo_before}) begin
            $display("The count went backwards after a write to the count offsets.");
            other_errors++;
        end
    endtask

    task automatic irq_test();
        logic [31:0] c;
        int          waited;
        data_read(`SYS_BASE + `SYS_COUNT_LO, c);
        data_write(`SYS_BASE + `SYS_COMPARE_HI, 32'd0, 4'hf);
        data_write(`SYS_BASE + `SYS_COMPARE_LO, c + 32'd40, 4'hf);
        waited = 0;
        while (!timer_irq && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!timer_irq) begin
            $display("timer_irq did not rise after compare was set near the count.");
            other_errors++;
        end
        repeat (20) @(negedge clk);
        if (!timer_irq) begin
            $display("timer_irq dropped while compare was still below the count.");
            other_errors++;
        end
        data_write(`SYS_BASE + `SYS_COMPARE_HI, '1, 4'hf);
        data_write(`SYS_BASE + `SYS_COMPARE_LO, '1, 4'hf);
        repeat (3) @(negedge clk);
        if (timer_irq) begin
            $display("timer_irq stayed high after compare was set to all ones.");
            other_errors++;
        end
    endtask

    task automatic arbitration_test();
        logic [31:0] v1;
        logic [31:0] v2;
        for (int i = 0; i < 10; i++) begin
            fork
                data_read(addr_list[i], v1);
                instr_read(addr_list[i + 10], v2);
            join
            if (!(data_done_at < instr_done_at)) begin
                $display("Data request did not finish first after a same-cycle start.");
                other_errors++;
            end
            fork
                instr_read(addr_list[i + 5], v2);
                begin
                    @(negedge clk);
                    data_write(`SYS_BASE + `SYS_LEDS, take_bits(8), 4'h1);
                end
            join
            if (!(instr_done_at < data_done_at)) begin
                $display("A granted instruction fetch was overtaken by a data request.");
                other_errors++;
            end
        end
    endtask

    initial begin
        lfsr_state    = 32'h576e_9f3c;
        reset         = 1'b1;
        instr_req     = '0;
        data_req      = '0;
        model_leds    = 8'd0;
        model_compare = '1;
        model_count   = 64'd0;
        exp_irq       = 1'b0;
        data_done_at  = 0;
        instr_done_at = 0;
        value_errors  = 0;
        other_errors  = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        ram_test();
        fault_test();
        led_count_test();
        irq_test();
        arbitration_test();
        repeat (4) @(negedge clk);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        #((TXN_LIMIT * 8 + 10 + IRQ_WAIT) * 4);
        $display("Timeout: the tests did not finish in the expected time.");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- soc_bus.f
+incdir+logic
logic/soc_bus_pkg.sv
logic/bus_arbiter.sv
logic/bus_decoder.sv
logic/ram.sv
logic/system_regs.sv
logic/timer_counter.sv
logic/soc_bus.sv
verification/soc_bus_properties.sv
verification/soc_bus_tb.sv

//--- Makefile
TOP = soc_bus_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f soc_bus.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f soc_bus.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
